// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal --timescale 1ns/100ps
TOP ?= periph_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/periph_input.txt ====
# op addr wstrb wdata pin expected, op is R read, W write or I interrupt level check
# expected is hex, - means don't care, + means above the previous read value
R 10000000 0 00000000 00 00000000
R 10000004 0 00000000 00 00000000
I 00000000 0 00000000 00 0
R 10000104 0 00000000 00 ffffffff
W 10000000 f ffffff5a 00 -
R 10000000 0 00000000 00 0000005a
W 10000004 1 123456c3 00 -
R 10000004 0 00000000 00 000000c3
W 10000004 8 000000a5 00 -
R 10000004 0 00000000 00 000000a5
R 10000008 0 00000000 3c 0000003c
W 10000008 f 000000ff 3c -
R 10000008 0 00000000 3c 0000003c
R 10000008 0 00000000 e1 000000e1
R 10000100 0 00000000 e1 -
R 10000100 0 00000000 e1 +
W 10000104 f 00000001 e1 -
I 00000000 0 00000000 e1 1
W 10000104 f ffffffff e1 -
I 00000000 0 00000000 e1 0
R 20000000 0 00000000 e1 00000000
R 1000000c 0 00000000 e1 00000000
R 10000108 0 00000000 e1 00000000
W 20000004 f 00000000 e1 -
W 1000000c f 00000000 e1 -
W 10000108 f 00000000 e1 -
R 10000000 0 00000000 e1 0000005a
R 10000004 0 00000000 e1 000000a5
R 10000104 0 00000000 e1 ffffffff
I 00000000 0 00000000 e1 0

// ==== bench/periph_properties.sv ====
// ==================================================
// Bus protocol and reset assertions, bound into the region decoder
// ==================================================
`timescale 1ns/100ps

module periph_properties (
    input logic                 clk,
    input logic                 resetn,
    input periph_pkg::bus_req_t req,
    input periph_pkg::bus_req_t gpio_req,
    input periph_pkg::bus_req_t timer_req,
    input periph_pkg::bus_rsp_t rsp
);

    // Every slave answers a request with a single ready pulse
    ready_single_pulse: assert property (
        @(posedge clk) disable iff (!resetn) rsp.ready |=> !rsp.ready
    ) else $error("ready was high for two consecutive cycles");

    // All ready flops clear on the reset edge, so the next cycle is quiet
    ready_low_in_reset: assert property (
        @(posedge clk) !resetn |=> !rsp.ready
    ) else $error("ready was high while reset was applied");

    // The region decode selects at most one slave
    one_slave_selected: assert property (
        @(posedge clk) disable iff (!resetn) $onehot0({gpio_req.valid, timer_req.valid})
    ) else $error("valid was forwarded to both slaves at once");

    // Fixed latency of one cycle for mapped and unmapped regions alike
    ready_follows_valid: assert property (
        @(posedge clk) disable iff (!resetn) (req.valid && !rsp.ready) |=> rsp.ready
    ) else $error("ready did not follow valid within one cycle");

endmodule

// Attach the checker to every decoder instance
bind periph_decoder periph_properties props_i (
    .clk       (clk),
    .resetn    (resetn),
    .req       (req),
    .gpio_req  (gpio_req),
    .timer_req (timer_req),
    .rsp       (rsp)
);

// ==== bench/periph_tb.sv ====
// ==================================================
// Testbench for the peripheral subsystem, replays the access list file
// Checks read data, ready latency, pin vectors and the timer interrupt
// ==================================================
`timescale 1ns/100ps

`include "periph_settings.svh"

module periph_tb;

    // Cycles allowed for ready before an access counts as hung
    localparam int ready_limit = 4;
    localparam periph_pkg::addr_t gpio_dir_addr = `PERIPH_GPIO_BASE + 32'(`PERIPH_GPIO_DIR_OFS);
    localparam periph_pkg::addr_t gpio_out_addr = `PERIPH_GPIO_BASE + 32'(`PERIPH_GPIO_OUT_OFS);

    logic clk;
    logic resetn;
    periph_pkg::bus_req_t req;
    periph_pkg::bus_rsp_t rsp;
    periph_pkg::gpio_t gpio_in;
    periph_pkg::gpio_t gpio_out;
    periph_pkg::gpio_t gpio_oe;
    logic timer_irq;

    // Access list as read from the data file, one entry per line
    string op_list[$];
    periph_pkg::addr_t addr_list[$];
    periph_pkg::wstrb_t strb_list[$];
    periph_pkg::data_t wdata_list[$];
    periph_pkg::gpio_t pin_list[$];
    string exp_list[$];
    int n_access;
    bit list_loaded;
    int checks;

    // Expected pin vectors, following the GPIO write rules
    periph_pkg::gpio_t model_dir;
    periph_pkg::gpio_t model_out;
    // Data of the previous read, used by the increasing time check
    periph_pkg::data_t last_rdata;

    periph_top dut_i (
        .clk       (clk),
        .resetn    (resetn),
        .req       (req),
        .rsp       (rsp),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out),
        .gpio_oe   (gpio_oe),
        .timer_irq (timer_irq)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped after an error");
    endtask

    function automatic periph_pkg::data_t hex_value(input string text);
        periph_pkg::data_t value;
        value = '0;
        void'($sscanf(text, "%h", value));
        return value;
    endfunction

    task automatic load_access_list();
        int fd;
        int fields;
        string line;
        string op;
        string exp;
        periph_pkg::addr_t addr;
        periph_pkg::wstrb_t strb;
        periph_pkg::data_t wdata;
        periph_pkg::gpio_t pin;
        fd = $fopen("bench/periph_input.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open the access list bench/periph_input.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Blank lines and lines starting with # carry no access
                if (line.len() > 1 && line[0] != "#") begin
                    fields = $sscanf(line, "%s %h %h %h %h %s", op, addr, strb, wdata, pin, exp);
                    if (fields != 6) begin
                        fail_run($sformatf("Malformed line in the access list: %s", line));
                    end else begin
                        op_list.push_back(op);
                        addr_list.push_back(addr);
                        strb_list.push_back(strb);
                        wdata_list.push_back(wdata);
                        pin_list.push_back(pin);
                        exp_list.push_back(exp);
                    end
                end
            end
            $fclose(fd);
        end
        n_access = op_list.size();
    endtask

    // Pin vectors must match the model at every sampling point
    task automatic check_pins();
        assert (gpio_oe == model_dir) else fail_run($sformatf(
            "FAIL at %0t: gpio_oe is %h, expected %h", $time, gpio_oe, model_dir));
        assert (gpio_out == model_out) else fail_run($sformatf(
            "FAIL at %0t: gpio_out is %h, expected %h", $time, gpio_out, model_out));
        checks++;
    endtask

    task automatic run_access(input int idx);
        int cycles;
        bit is_write;
        periph_pkg::data_t rdata;
        periph_pkg::data_t exp_val;
        is_write = op_list[idx] == "W";
        exp_val = hex_value(exp_list[idx]);
        // New pin value first, so it clears the synchronizer before the access
        @(posedge clk);
        gpio_in <= pin_list[idx];
        repeat (3) @(posedge clk);
        if (op_list[idx] == "I") begin
            @(negedge clk);
            assert (timer_irq == exp_val[0]) else fail_run($sformatf(
                "FAIL at %0t: timer_irq is %b, expected %b", $time, timer_irq, exp_val[0]));
            check_pins();
        end else if (op_list[idx] == "R" || is_write) begin
            req.valid <= 1'b1;
            req.addr <= addr_list[idx];
            req.wstrb <= is_write ? strb_list[idx] : 4'h0;
            req.wdata <= wdata_list[idx];
            // This negedge lies before the edge that first samples valid
            // Ready is due at the negedge right after that sampling edge
            @(negedge clk);
            cycles = 0;
            while (!rsp.ready && cycles < ready_limit) begin
                @(negedge clk);
                cycles++;
            end
            assert (rsp.ready) else fail_run($sformatf(
                "Access to address %h got no ready", addr_list[idx]));
            assert (cycles == 1) else fail_run($sformatf(
                "FAIL at %0t: ready came after %0d cycles, expected 1", $time, cycles));
            rdata = rsp.rdata;
            // The write lands on the edge that raises ready
            if (is_write && strb_list[idx] != 4'h0) begin
                if (addr_list[idx] == gpio_dir_addr) begin
                    model_dir = wdata_list[idx][`PERIPH_GPIO_NR-1:0];
                end
                if (addr_list[idx] == gpio_out_addr) begin
                    model_out = wdata_list[idx][`PERIPH_GPIO_NR-1:0];
                end
            end
            check_pins();
            if (!is_write) begin
                if (exp_list[idx] == "+") begin
                    assert (rdata > last_rdata) else fail_run($sformatf(
                        "FAIL at %0t: read %h is not above the previous %h",
                        $time, rdata, last_rdata));
                end else if (exp_list[idx] != "-") begin
                    assert (rdata == exp_val) else fail_run($sformatf(
                        "FAIL at %0t: read of %h returned %h, expected %h",
                        $time, addr_list[idx], rdata, exp_val));
                end
                last_rdata = rdata;
                checks++;
            end
            // The master drops valid at the ready edge
            @(posedge clk);
            req.valid <= 1'b0;
            req.wstrb <= 4'h0;
        end else begin
            fail_run($sformatf("Unknown operation %s in the access list", op_list[idx]));
        end
    endtask

    // Each access needs about six cycles, twenty per line leaves ample margin
    initial begin
        wait (list_loaded);
        repeat (n_access * 20 + 50) @(posedge clk);
        fail_run("Watchdog expired before the access list was finished");
    end

    initial begin
        resetn = 1'b0;
        req = '0;
        gpio_in = '0;
        model_dir = '0;
        model_out = '0;
        last_rdata = '0;
        checks = 0;
        list_loaded = 1'b0;
        load_access_list();
        list_loaded = 1'b1;
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        for (int i = 0; i < n_access; i++) begin
            run_access(i);
        end
        if (checks == 0) begin
            fail_run("The access list held no checks");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// ==== build.f ====
+incdir+src
src/periph_pkg.sv
src/periph_decoder.sv
src/gpio_ctrl.sv
src/mtimer.sv
src/periph_top.sv
bench/periph_properties.sv
bench/periph_tb.sv

// ==== src/gpio_ctrl.sv ====
// ==================================================
// GPIO slave with direction, output value and synchronized input registers
// Pins come out as separate in, out and enable vectors for the board pad
// ==================================================
`timescale 1ns/100ps

`include "periph_settings.svh"

module gpio_ctrl (
    input  logic                 clk,
    input  logic                 resetn,
    input  periph_pkg::bus_req_t req,
    output periph_pkg::bus_rsp_t rsp,
    input  periph_pkg::gpio_t    pin_in,
    output periph_pkg::gpio_t    pin_out,
    output periph_pkg::gpio_t    pin_oe
);

    logic [`PERIPH_REGION_LSB-1:0] ofs;
    logic wr;
    logic ack;
    logic ready_q;
    periph_pkg::data_t rdata_q;
    // Direction register, 1 drives the pin
    periph_pkg::gpio_t dir_q;
    // Output value register
    periph_pkg::gpio_t out_q;
    // Two-flop synchronizer for the asynchronous pin inputs
    periph_pkg::gpio_t sync_meta;
    periph_pkg::gpio_t sync_q;

    // The decoder has already checked the region, only the offset is left
    assign ofs = req.addr[`PERIPH_REGION_LSB-1:0];
    assign wr = |req.wstrb;

    // First cycle of a request, which is also the edge that raises ready
    assign ack = req.valid && !ready_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= ack;
        end
    end

    // All pins start as inputs with a low output value
    always_ff @(posedge clk) begin
        if (!resetn) begin
            dir_q <= '0;
            out_q <= '0;
        end else if (ack && wr) begin
            // Any strobe bit writes the whole register
            if (ofs == `PERIPH_GPIO_DIR_OFS) begin
                dir_q <= req.wdata[`PERIPH_GPIO_NR-1:0];
            end
            if (ofs == `PERIPH_GPIO_OUT_OFS) begin
                out_q <= req.wdata[`PERIPH_GPIO_NR-1:0];
            end
            // The input offset is read only and ignores writes
        end
    end

    // Pin values settle through both stages before a read can see them
    always_ff @(posedge clk) begin
        sync_meta <= pin_in;
        sync_q <= sync_meta;
    end

    // Read data is captured at the ack edge and held during the ready cycle
    always_ff @(posedge clk) begin
        if (ack) begin
            case (ofs)
                `PERIPH_GPIO_DIR_OFS: rdata_q <= periph_pkg::data_t'(dir_q);
                `PERIPH_GPIO_OUT_OFS: rdata_q <= periph_pkg::data_t'(out_q);
                `PERIPH_GPIO_IN_OFS: rdata_q <= periph_pkg::data_t'(sync_q);
                default: rdata_q <= '0;
            endcase
        end
    end

    assign rsp.ready = ready_q;
    assign rsp.rdata = rdata_q;

    // Registers drive the pad controls directly
    assign pin_oe = dir_q;
    assign pin_out = out_q;

endmodule

// ==== src/mtimer.sv ====
// ==================================================
// Machine timer slave with a free-running counter and compare interrupt
// ==================================================
`timescale 1ns/100ps

`include "periph_settings.svh"

module mtimer (
    input  logic                 clk,
    input  logic                 resetn,
    input  periph_pkg::bus_req_t req,
    output periph_pkg::bus_rsp_t rsp,
    output logic                 irq
);

    logic [`PERIPH_REGION_LSB-1:0] ofs;
    logic wr;
    logic ack;
    logic ready_q;
    periph_pkg::data_t rdata_q;
    // Free-running time counter
    periph_pkg::data_t count_q;
    // Compare value, all ones keeps the interrupt off
    periph_pkg::data_t cmp_q;
    logic irq_q;

    // Region is resolved upstream, so only the low bits matter here
    assign ofs = req.addr[`PERIPH_REGION_LSB-1:0];
    assign wr = |req.wstrb;
    assign ack = req.valid && !ready_q;

    // One ready pulse per request, in the cycle after valid is first seen
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= ack;
        end
    end

    // Counts every cycle unless software loads a new time value
    always_ff @(posedge clk) begin
        if (!resetn) begin
            count_q <= '0;
        end else if (ack && wr && ofs == `PERIPH_TIMER_TIME_OFS) begin
            count_q <= req.wdata;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cmp_q <= '1;
        end else if (ack && wr && ofs == `PERIPH_TIMER_CMP_OFS) begin
            cmp_q <= req.wdata;
        end
    end

    // Level interrupt, lags the comparison by one cycle
    // Writing a compare value already passed raises it on the next edge
    always_ff @(posedge clk) begin
        if (!resetn) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= count_q >= cmp_q;
        end
    end

    // The time read returns the count as it stands at the ack edge
    always_ff @(posedge clk) begin
        if (ack) begin
            case (ofs)
                `PERIPH_TIMER_TIME_OFS: rdata_q <= count_q;
                `PERIPH_TIMER_CMP_OFS: rdata_q <= cmp_q;
                default: rdata_q <= '0;
            endcase
        end
    end

    assign rsp.ready = ready_q;
    assign rsp.rdata = rdata_q;
    assign irq = irq_q;

endmodule

// ==== src/periph_decoder.sv ====
// ==================================================
// Region decoder that steers each access to GPIO, timer or default slave
// ==================================================
`timescale 1ns/100ps

`include "periph_settings.svh"

module periph_decoder (
    input  logic                 clk,
    input  logic                 resetn,
    input  periph_pkg::bus_req_t req,
    output periph_pkg::bus_req_t gpio_req,
    output periph_pkg::bus_req_t timer_req,
    input  periph_pkg::bus_rsp_t gpio_rsp,
    input  periph_pkg::bus_rsp_t timer_rsp,
    output periph_pkg::bus_rsp_t rsp
);

    // Region bases as typed constants so the upper bits can be sliced
    localparam periph_pkg::addr_t gpio_base = `PERIPH_GPIO_BASE;
    localparam periph_pkg::addr_t timer_base = `PERIPH_TIMER_BASE;

    logic sel_gpio;
    logic sel_timer;
    logic sel_none;
    // Ready flop of the built-in responder for unmapped regions
    logic dflt_ready;

    // Only the upper address bits pick the region
    assign sel_gpio = req.addr[31:`PERIPH_REGION_LSB] == gpio_base[31:`PERIPH_REGION_LSB];
    assign sel_timer = req.addr[31:`PERIPH_REGION_LSB] == timer_base[31:`PERIPH_REGION_LSB];
    assign sel_none = !sel_gpio && !sel_timer;

    // Both slaves see the full request, but valid reaches only the selected one
    always_comb begin
        gpio_req = req;
        gpio_req.valid = req.valid && sel_gpio;
        timer_req = req;
        timer_req.valid = req.valid && sel_timer;
    end

    // Unmapped accesses get the same single pulse one cycle after valid
    // Holding off while the pulse is high keeps it from repeating at the ack edge
    always_ff @(posedge clk) begin
        if (!resetn) begin
            dflt_ready <= 1'b0;
        end else begin
            dflt_ready <= req.valid && sel_none && !dflt_ready;
        end
    end

    // The address is still stable during the ready cycle, so the same
    // selection steers the response back without any extra register
    always_comb begin
        rsp.ready = (sel_gpio && gpio_rsp.ready)
                  || (sel_timer && timer_rsp.ready)
                  || dflt_ready;
        if (sel_gpio) begin
            rsp.rdata = gpio_rsp.rdata;
        end else if (sel_timer) begin
            rsp.rdata = timer_rsp.rdata;
        end else begin
            // Unmapped regions always read as zero
            rsp.rdata = '0;
        end
    end

endmodule

// ==== src/periph_pkg.sv ====
// ==================================================
// Bus word types and request/response structs shared by all blocks
// ==================================================

`include "periph_settings.svh"

package periph_pkg;

    // Byte address as issued by the master
    typedef logic [31:0] addr_t;

    // One bus word, used for both write and read data
    typedef logic [31:0] data_t;

    // Byte write strobes
    // A nonzero value marks the access as a write of the whole register
    typedef logic [3:0] wstrb_t;

    // One bit per GPIO pin
    typedef logic [`PERIPH_GPIO_NR-1:0] gpio_t;

    // Request from the master towards a slave
    // The master keeps every field stable while valid is high
    typedef struct packed {
        logic   valid;
        addr_t  addr;
        wstrb_t wstrb;
        data_t  wdata;
    } bus_req_t;

    // Response from a slave back to the master
    // ready is a single cycle pulse and rdata only counts while it is high
    typedef struct packed {
        logic  ready;
        data_t rdata;
    } bus_rsp_t;

endpackage

// ==== src/periph_settings.svh ====
// ==================================================
// Pin count, region bases and register offsets of the peripheral bus
// Included by the package and by every module that decodes addresses
// ==================================================
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

// Number of GPIO pins brought out of the subsystem
`define PERIPH_GPIO_NR 8

// Address bits at and above this index select a region
// The bits below it select a register inside the region
`define PERIPH_REGION_LSB 8

// Region bases, only bits 31 to 8 take part in the decode
`define PERIPH_GPIO_BASE 32'h1000_0000
`define PERIPH_TIMER_BASE 32'h1000_0100

// GPIO register offsets inside its region
// Direction uses 1 for output and 0 for input
`define PERIPH_GPIO_DIR_OFS 8'h00
`define PERIPH_GPIO_OUT_OFS 8'h04
`define PERIPH_GPIO_IN_OFS 8'h08

// Machine timer register offsets inside its region
`define PERIPH_TIMER_TIME_OFS 8'h00
`define PERIPH_TIMER_CMP_OFS 8'h04

`endif

// ==== src/periph_top.sv ====
// ==================================================
// Peripheral subsystem top, decoder fanning out to the GPIO and timer slaves
// The board wrapper adds the tristate pads on the GPIO vectors
// ==================================================
`timescale 1ns/100ps

module periph_top (
    input  logic                 clk,
    input  logic                 resetn,
    input  periph_pkg::bus_req_t req,
    output periph_pkg::bus_rsp_t rsp,
    input  periph_pkg::gpio_t    gpio_in,
    output periph_pkg::gpio_t    gpio_out,
    output periph_pkg::gpio_t    gpio_oe,
    output logic                 timer_irq
);

    // Per-slave request and response links behind the decoder
    periph_pkg::bus_req_t gpio_req;
    periph_pkg::bus_req_t timer_req;
    periph_pkg::bus_rsp_t gpio_rsp;
    periph_pkg::bus_rsp_t timer_rsp;

    // Region decode and response steering, plus the unmapped responder
    periph_decoder decoder_i (
        .clk       (clk),
        .resetn    (resetn),
        .req       (req),
        .gpio_req  (gpio_req),
        .timer_req (timer_req),
        .gpio_rsp  (gpio_rsp),
        .timer_rsp (timer_rsp),
        .rsp       (rsp)
    );

    // GPIO registers and the input synchronizer
    gpio_ctrl gpio_i (
        .clk     (clk),
        .resetn  (resetn),
        .req     (gpio_req),
        .rsp     (gpio_rsp),
        .pin_in  (gpio_in),
        .pin_out (gpio_out),
        .pin_oe  (gpio_oe)
    );

    // Machine timer driving the interrupt level
    mtimer timer_i (
        .clk    (clk),
        .resetn (resetn),
        .req    (timer_req),
        .rsp    (timer_rsp),
        .irq    (timer_irq)
    );

endmodule
